/* tb/mcalu_tests.hex */
// op  a    b    imm  tag  result  class (0 illegal, 1 multiplier, 2 converter)
// Every field is one hex word, and a line with class f ends the list
0 0003 0005 0000 1 000f 1
0 fffd 0007 0000 2 ffeb 1
0 8000 ffff 0000 3 8000 1
1 8000 8000 0000 4 4000 1
1 ffff 0002 0000 5 ffff 1
1 7fff 7fff 0000 6 3fff 1
2 0064 0009 fff6 7 fc18 1
2 1234 0000 0010 8 2340 1
3 0000 0000 0000 9 0000 2
3 0001 0000 0000 a 3c00 2
3 ffff 0000 0000 b bc00 2
3 7fff 0000 0000 c 7800 2
3 8000 0000 0000 d f800 2
3 0803 0000 0000 e 6802 2
4 3c00 0000 0000 f 0001 2
4 bc00 0000 0000 0 ffff 2
4 c100 0000 0000 1 fffe 2
4 7c00 0000 0000 2 7fff 2
4 7e00 0000 0000 3 0000 2
4 77ff 0000 0000 4 7ff0 2
5 3e00 0000 0000 5 3c00 2
5 c100 0000 0000 6 c000 2
5 b800 0000 0000 7 8000 2
6 1234 5678 9abc 8 0000 0
7 ffff ffff ffff 9 0000 0
f 0000 0000 0000 0 0000 f

/* flist.f */
+incdir+include
src/mcalu_pkg.sv
src/mcalu_int_mul.sv
src/mcalu_fp_convert.sv
src/mcalu_retire.sv
src/mcalu_top.sv
tb/mcalu_sva.sv
tb/mcalu_tb.sv

/* Makefile */
# Verilator build and run for the multicycle arithmetic unit

TOP := mcalu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o V$(TOP)

# The log decides the verdict, a run that stops early has no pass line
run: build
	./obj_dir/V$(TOP) > run.log 2>&1 || true
	@cat run.log
	@if grep -q ">>> FAIL" run.log; then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" run.log; then echo "Simulation ended without a verdict"; exit 1; fi

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log

/* tb/mcalu_tb.sv */
`timescale 1ns/1ps

`include "mcalu_macros.svh"

module mcalu_tb import mcalu_pkg::*; ();

	// Each vector in the data file is seven words long
	localparam int MAX_TESTS = 64;
	localparam int WORDS     = 7;
	// Edges to wait for ack_o before a request counts as lost
	localparam int ACK_WAIT  = 40;

	logic        clk_i;
	logic        arst_n_i;
	logic        req_i;
	alu_op_e     op_i;
	half_value_t a_i, b_i, imm_i;
	tid_t        tid_i;
	logic        ack_o;
	half_value_t result_o;
	tid_t        tid_o;

	logic [15:0] vec_mem [MAX_TESTS*WORDS];
	int          n_tests;
	int          seed;
	int          value_errors;
	int          other_errors;
	int          cycle_count;
	int          cycle_limit;

	mcalu_top DUT (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.req_i    (req_i),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.imm_i    (imm_i),
		.tid_i    (tid_i),
		.ack_o    (ack_o),
		.result_o (result_o),
		.tid_o    (tid_o)
	);

	// Handshake checks also see the internal issue pulses
	bind mcalu_top mcalu_sva u_sva (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.req_i       (req_i),
		.ack_i       (ack_o),
		.result_i    (result_o),
		.tid_i       (tid_o),
		.mul_issue_i (mul_issue),
		.cvt_issue_i (cvt_issue)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// ======================================================================
	// Helpers
	// ======================================================================

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
			value_errors++;
		end
	endtask

	// One edge registers the issue, the unit adds its latency, one edge retires
	function automatic int expected_latency(input logic [15:0] cls);
		int lat;
		case (cls)
			16'h0000: lat = 1;
			16'h0001: lat = `MCALU_MUL_LAT + 2;
			default:  lat = `MCALU_CVT_LAT + 2;
		endcase
		return lat;
	endfunction

	// Runs one vector through the whole four-phase exchange
	task automatic run_vector(input int idx);
		int          base;
		int          edges;
		int unsigned gap;
		int unsigned hold;
		tid_t        sent_tid;
		half_value_t held_result;
		tid_t        held_tid;
		base     = idx * WORDS;
		sent_tid = tid_t'(vec_mem[base+4][3:0]);
		gap      = $unsigned($random(seed)) % 4;
		hold     = $unsigned($random(seed)) % 5;
		repeat (gap) @(negedge clk_i);
		op_i  = alu_op_e'(vec_mem[base][2:0]);
		a_i   = vec_mem[base+1];
		b_i   = vec_mem[base+2];
		imm_i = vec_mem[base+3];
		tid_i = sent_tid;
		req_i = 1'b1;
		edges = 0;
		while (!ack_o && edges < ACK_WAIT) begin
			@(negedge clk_i);
			edges++;
		end
		if (!ack_o) begin
			$display("Test %0d got no acknowledge within %0d cycles", idx, ACK_WAIT);
			other_errors++;
		end else begin
			check_value("ack_o latency", 16'(expected_latency(vec_mem[base+6])), 16'(edges));
			check_value("result_o", vec_mem[base+5], result_o);
			check_value("tid_o", 16'(sent_tid), 16'(tid_o));
		end
		// Back-pressure, the owner keeps req_i high and the answer must not move
		held_result = result_o;
		held_tid    = tid_o;
		repeat (hold) begin
			@(negedge clk_i);
			check_value("ack_o", 16'h0001, 16'(ack_o));
			check_value("result_o", held_result, result_o);
			check_value("tid_o", 16'(held_tid), 16'(tid_o));
		end
		req_i = 1'b0;
		// Operands are free to change once the request is gone
		a_i   = half_value_t'($random(seed));
		b_i   = half_value_t'($random(seed));
		imm_i = half_value_t'($random(seed));
		@(negedge clk_i);
		check_value("ack_o", 16'h0000, 16'(ack_o));
	endtask

	// ======================================================================
	// Stimulus and verdict
	// ======================================================================

	initial begin : stimulus
		arst_n_i     = 1'b0;
		req_i        = 1'b0;
		op_i         = OP_MUL;
		a_i          = '0;
		b_i          = '0;
		imm_i        = '0;
		tid_i        = '0;
		seed         = 32'hb280_06b3;
		value_errors = 0;
		other_errors = 0;
		$readmemh("tb/mcalu_tests.hex", vec_mem);
		n_tests = 0;
		while (n_tests < MAX_TESTS && vec_mem[n_tests*WORDS+6] == 16'h000f ? 1'b0 :
			n_tests < MAX_TESTS) begin
			n_tests++;
		end
		// Worst case per vector stays below twenty cycles, the rest covers reset
		cycle_limit = n_tests * 20 + 100;
		if (n_tests == 0) begin
			$display("The data file held no test vectors");
			other_errors++;
		end
		repeat (10) @(posedge clk_i);
		@(negedge clk_i);
		arst_n_i = 1'b1;
		@(negedge clk_i);
		check_value("ack_o", 16'h0000, 16'(ack_o));
		check_value("result_o", 16'h0000, result_o);
		check_value("tid_o", 16'h0000, 16'(tid_o));
		for (int i = 0; i < n_tests; i++) begin
			run_vector(i);
		end
		$display("Tests: %0d, value errors: %0d, other errors: %0d",
			n_tests, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_i);
			cycle_count++;
		end
		$display("The run passed its limit of %0d cycles and was stopped", cycle_limit);
		$display(">>> FAIL");
		$finish;
	end

endmodule

/* tb/mcalu_sva.sv */
`timescale 1ns/1ps

module mcalu_sva import mcalu_pkg::*; (
	input logic        clk_i,
	input logic        arst_n_i,
	input logic        req_i,
	input logic        ack_i,
	input half_value_t result_i,
	input tid_t        tid_i,
	input logic        mul_issue_i,
	input logic        cvt_issue_i
);

	// ======================================================================
	// Four-phase handshake
	// ======================================================================

	// An acknowledge only answers a request that was sampled on the edge before
	ack_rise_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$rose(ack_i) |-> $past(req_i))
		else $error("ack_o rose while req_i was low");

	// The returned word and tag hold still for as long as ack_o is high
	ack_holds_result: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(ack_i && $past(ack_i)) |-> ($stable(result_i) && $stable(tid_i)))
		else $error("result_o or tid_o changed while ack_o was high");

	// ack_o only drops once req_i has been seen low
	ack_fall_after_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		$fell(ack_i) |-> !$past(req_i))
		else $error("ack_o fell while req_i was still high");

	// ======================================================================
	// Issue pulses
	// ======================================================================

	mul_issue_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		mul_issue_i |=> !mul_issue_i)
		else $error("mul_issue lasted more than one cycle");

	cvt_issue_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		cvt_issue_i |=> !cvt_issue_i)
		else $error("cvt_issue lasted more than one cycle");

endmodule

/* src/mcalu_top.sv */
`timescale 1ns/1ps

module mcalu_top import mcalu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        req_i,
	input  alu_op_e     op_i,
	input  half_value_t a_i,
	input  half_value_t b_i,
	input  half_value_t imm_i,
	input  tid_t        tid_i,
	output logic        ack_o,
	output half_value_t result_o,
	output tid_t        tid_o
);

	// Issue pulses from the FSM and results back from the two units
	logic        mul_issue, cvt_issue;
	logic        mul_valid, cvt_valid;
	half_value_t mul_result, cvt_result;

	// ======================================================================
	// Execution units
	// ======================================================================

	// Operands come straight from the ports, the handshake keeps them stable
	mcalu_int_mul u_int_mul (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.issue_i  (mul_issue),
		.op_i     (op_i),
		.a_i      (a_i),
		.b_i      (b_i),
		.imm_i    (imm_i),
		.valid_o  (mul_valid),
		.result_o (mul_result)
	);

	mcalu_fp_convert u_fp_convert (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.issue_i  (cvt_issue),
		.op_i     (op_i),
		.a_i      (a_i),
		.valid_o  (cvt_valid),
		.result_o (cvt_result)
	);

	// ======================================================================
	// Handshake and retire
	// ======================================================================

	mcalu_retire u_retire (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.req_i        (req_i),
		.op_i         (op_i),
		.tid_i        (tid_i),
		.mul_valid_i  (mul_valid),
		.cvt_valid_i  (cvt_valid),
		.mul_result_i (mul_result),
		.cvt_result_i (cvt_result),
		.mul_issue_o  (mul_issue),
		.cvt_issue_o  (cvt_issue),
		.ack_o        (ack_o),
		.result_o     (result_o),
		.tid_o        (tid_o)
	);

endmodule

/* src/mcalu_retire.sv */
`timescale 1ns/1ps

module mcalu_retire import mcalu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        req_i,
	input  alu_op_e     op_i,
	input  tid_t        tid_i,
	input  logic        mul_valid_i,
	input  logic        cvt_valid_i,
	input  half_value_t mul_result_i,
	input  half_value_t cvt_result_i,
	output logic        mul_issue_o,
	output logic        cvt_issue_o,
	output logic        ack_o,
	output half_value_t result_o,
	output tid_t        tid_o
);

	typedef enum logic [1:0] {
		IDLE = 2'd0,
		WAIT = 2'd1,
		ACK  = 2'd2
	} state_e;

	state_e state_q;

	// Set when the operation in flight went to the converter
	logic wait_cvt_q;

	logic        is_mul, is_cvt;
	logic        done;
	half_value_t unit_result;

	// ======================================================================
	// Opcode class and result selection
	// ======================================================================

	assign is_mul = op_i inside {OP_MUL, OP_MULH, OP_MULI};
	assign is_cvt = op_i inside {OP_I2F, OP_F2I, OP_FTRUNC};

	// Only the unit that got the issue pulse is listened to
	assign done        = wait_cvt_q ? cvt_valid_i : mul_valid_i;
	assign unit_result = wait_cvt_q ? cvt_result_i : mul_result_i;

	// ======================================================================
	// Handshake FSM
	// ======================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q     <= IDLE;
			wait_cvt_q  <= 1'b0;
			mul_issue_o <= 1'b0;
			cvt_issue_o <= 1'b0;
			ack_o       <= 1'b0;
			result_o    <= '0;
			tid_o       <= '0;
		end else begin
			// Issue pulses last one cycle unless set again below
			mul_issue_o <= 1'b0;
			cvt_issue_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (req_i && is_mul) begin
						mul_issue_o <= 1'b1;
						wait_cvt_q  <= 1'b0;
						state_q     <= WAIT;
					end else if (req_i && is_cvt) begin
						cvt_issue_o <= 1'b1;
						wait_cvt_q  <= 1'b1;
						state_q     <= WAIT;
					end else if (req_i) begin
						// Illegal code, answered on the next edge with zero
						result_o <= '0;
						tid_o    <= tid_i;
						ack_o    <= 1'b1;
						state_q  <= ACK;
					end
				end
				WAIT: begin
					// The tag is still held by the owner, so it is taken here
					if (done) begin
						result_o <= unit_result;
						tid_o    <= tid_i;
						ack_o    <= 1'b1;
						state_q  <= ACK;
					end
				end
				ACK: begin
					if (!req_i) begin
						ack_o   <= 1'b0;
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

endmodule

/* src/mcalu_fp_convert.sv */
`timescale 1ns/1ps

`include "mcalu_macros.svh"

module mcalu_fp_convert import mcalu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        issue_i,
	input  alu_op_e     op_i,
	input  half_value_t a_i,
	output logic        valid_o,
	output half_value_t result_o
);

	// Four working stages, the rest of the latency is balance registers
	localparam int BAL = `MCALU_CVT_LAT - 4;

	// Valid bits of the four working stages and of the balance chain
	logic           u_vld, n_vld, r_vld, p_vld;
	logic [BAL-1:0] bal_vld;

	// Unpack stage
	alu_op_e     u_op;
	logic        u_sign;
	half_value_t u_mag;
	logic [4:0]  u_exp;
	logic [10:0] u_frac;

	// Normalize and shift stage
	logic [3:0]  lead;
	half_value_t n_val_d, n_val;
	logic [4:0]  n_exp_d, n_exp;
	logic        n_sat_d, n_sat, n_nan_d, n_nan;
	alu_op_e     n_op;
	logic        n_sign, n_zero;

	// Round and saturate stage
	logic        round_up;
	logic [10:0] rnd_man;
	half_value_t r_int_d, r_int;
	alu_op_e     r_op;
	logic        r_sign, r_zero;
	logic [4:0]  r_exp;
	logic [9:0]  r_man;

	// Pack stage and balance chain
	half_value_t p_res_d, p_res;
	half_value_t bal_res [BAL];

	// Index of the highest set bit, zero for a zero word
	function automatic logic [3:0] msb_index(input half_value_t v);
		logic [3:0] idx;
		idx = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (v[i]) begin
				idx = 4'(i);
			end
		end
		return idx;
	endfunction

	// ======================================================================
	// Normalize or shift
	// ======================================================================

	always_comb begin
		lead    = msb_index(u_mag);
		n_val_d = '0;
		n_exp_d = '0;
		n_sat_d = 1'b0;
		n_nan_d = 1'b0;
		case (u_op)
			// Move the leading one up to bit 15, its position gives the exponent
			OP_I2F: begin
				n_val_d = u_mag << (4'd15 - lead);
				n_exp_d = 5'd15 + 5'(lead);
			end
			// Exponent 25 means the 11-bit significand is already an integer
			OP_F2I: begin
				n_nan_d = (u_exp == 5'd31) && (u_frac[9:0] != 10'd0);
				n_sat_d = (u_exp >= 5'd30);
				if (u_exp >= 5'd25) begin
					n_val_d = 16'(u_frac) << (u_exp - 5'd25);
				end else if (u_exp >= 5'd15) begin
					n_val_d = 16'(u_frac) >> (5'd25 - u_exp);
				end
			end
			// Clear the fraction bits below the binary point, keep the sign
			OP_FTRUNC: begin
				if (u_exp < 5'd15) begin
					n_val_d = {u_sign, 15'd0};
				end else if (u_exp >= 5'd25) begin
					n_val_d = {u_sign, u_exp, u_frac[9:0]};
				end else begin
					n_val_d = {u_sign, u_exp, u_frac[9:0] & (10'h3FF << (5'd25 - u_exp))};
				end
			end
			default: begin
				n_val_d = '0;
			end
		endcase
	end

	// ======================================================================
	// Round or saturate
	// ======================================================================

	// Nearest even, guard is bit 4 and bits 3 to 0 are sticky
	assign round_up = n_val[4] & ((|n_val[3:0]) | n_val[5]);
	assign rnd_man  = {1'b0, n_val[14:5]} + 11'(round_up);

	always_comb begin
		if (n_op != OP_F2I) begin
			r_int_d = n_val;
		end else if (n_nan) begin
			r_int_d = '0;
		end else if (n_sat) begin
			r_int_d = n_sign ? 16'h8000 : 16'h7FFF;
		end else begin
			r_int_d = n_sign ? -n_val : n_val;
		end
	end

	// ======================================================================
	// Pack
	// ======================================================================

	// An exponent of 31 after rounding means the value went past 65504
	always_comb begin
		if (r_op != OP_I2F) begin
			p_res_d = r_int;
		end else if (r_zero) begin
			p_res_d = '0;
		end else if (r_exp == 5'd31) begin
			p_res_d = {r_sign, 5'd31, 10'd0};
		end else begin
			p_res_d = {r_sign, r_exp, r_man};
		end
	end

	// ======================================================================
	// Pipeline registers
	// ======================================================================

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			u_vld   <= 1'b0;
			n_vld   <= 1'b0;
			r_vld   <= 1'b0;
			p_vld   <= 1'b0;
			bal_vld <= '0;
		end else begin
			u_vld   <= issue_i;
			n_vld   <= u_vld;
			r_vld   <= n_vld;
			p_vld   <= r_vld;
			bal_vld <= {bal_vld[BAL-2:0], p_vld};
		end
	end

	always_ff @(posedge clk_i) begin
		// Unpack, the integer magnitude of 8000 stays 8000
		u_op   <= op_i;
		u_sign <= a_i[15];
		u_mag  <= a_i[15] ? -a_i : a_i;
		u_exp  <= a_i[14:10];
		u_frac <= {|a_i[14:10], a_i[9:0]};
		n_op   <= u_op;
		n_sign <= u_sign;
		n_zero <= (u_mag == '0);
		n_val  <= n_val_d;
		n_exp  <= n_exp_d;
		n_sat  <= n_sat_d;
		n_nan  <= n_nan_d;
		// A carry out of the mantissa bumps the exponent and leaves zeros
		r_op   <= n_op;
		r_sign <= n_sign;
		r_zero <= n_zero;
		r_exp  <= n_exp + 5'(rnd_man[10]);
		r_man  <= rnd_man[9:0];
		r_int  <= r_int_d;
		p_res  <= p_res_d;
		bal_res[0] <= p_res;
		for (int i = 1; i < BAL; i++) begin
			bal_res[i] <= bal_res[i-1];
		end
	end

	assign valid_o  = bal_vld[BAL-1];
	assign result_o = bal_res[BAL-1];

endmodule

/* src/mcalu_int_mul.sv */
`timescale 1ns/1ps

`include "mcalu_macros.svh"

module mcalu_int_mul import mcalu_pkg::*; (
	input  logic        clk_i,
	input  logic        arst_n_i,
	input  logic        issue_i,
	input  alu_op_e     op_i,
	input  half_value_t a_i,
	input  half_value_t b_i,
	input  half_value_t imm_i,
	output logic        valid_o,
	output half_value_t result_o
);

	localparam int LAT = `MCALU_MUL_LAT;

	// Second factor, the immediate for MULI and b otherwise
	half_value_t        mul_b;
	logic signed [31:0] product;
	half_value_t        sel;

	// Delay line, entry 0 is loaded on the edge that samples issue_i
	logic [LAT-1:0] vld_q;
	half_value_t    res_q [LAT];

	// ======================================================================
	// Product and half selection
	// ======================================================================

	assign mul_b   = (op_i == OP_MULI) ? imm_i : b_i;
	assign product = $signed(a_i) * $signed(mul_b);

	// MULH keeps the upper half of the signed product, the others the lower
	always_comb begin
		if (op_i == OP_MULH) begin
			sel = product[31:16];
		end else begin
			sel = product[15:0];
		end
	end

	// ======================================================================
	// Delay line
	// ======================================================================

	// Valid bits are control state and come out of reset clear
	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[LAT-2:0], issue_i};
		end
	end

	// Product words shift along with their valid bits
	always_ff @(posedge clk_i) begin
		res_q[0] <= sel;
		for (int i = 1; i < LAT; i++) begin
			res_q[i] <= res_q[i-1];
		end
	end

	assign valid_o  = vld_q[LAT-1];
	assign result_o = res_q[LAT-1];

endmodule

/* src/mcalu_pkg.sv */
`include "mcalu_macros.svh"

package mcalu_pkg;

	// ======================================================================
	// Data and tag words
	// ======================================================================

	// One operand or result word, either an integer or an IEEE half
	typedef logic [`MCALU_DATA_W-1:0] half_value_t;

	// Thread tag that travels with an operation and comes back with it
	typedef logic [`MCALU_TID_W-1:0] tid_t;

	// ======================================================================
	// Opcodes
	// ======================================================================

	// The first three go to the multiplier, the next three to the converter
	// Codes 6 and 7 are illegal and are answered at once with a zero result
	typedef enum logic [2:0] {
		OP_MUL    = 3'd0,
		OP_MULH   = 3'd1,
		OP_MULI   = 3'd2,
		OP_I2F    = 3'd3,
		OP_F2I    = 3'd4,
		OP_FTRUNC = 3'd5
	} alu_op_e;

endpackage

/* include/mcalu_macros.svh */
`ifndef MCALU_MACROS_SVH
`define MCALU_MACROS_SVH

// ==========================================================================
// Latencies of the two execution units
// ==========================================================================

// Edges from the issue edge in the retire FSM to the multiplier valid
`define MCALU_MUL_LAT 8

// Edges from the issue edge in the retire FSM to the converter valid
`define MCALU_CVT_LAT 7

// ==========================================================================
// Widths
// ==========================================================================

// Half-word operand and result width
`define MCALU_DATA_W 16

// Thread tag width, so up to sixteen threads can be told apart
`define MCALU_TID_W 4

`endif
